/* line_store.sv */
`timescale 1ns/10ps
`include "rdcache_consts.svh"

module line_store (
  input  logic                clk,
  input  logic                len_reset,

  input  logic                lookup_en_i,
  input  rdcache_pkg::index_t lookup_index_i,

  input  logic                fill_en_i,
  input  rdcache_pkg::index_t fill_index_i,
  input  rdcache_pkg::tag_t   fill_tag_i,
  input  rdcache_pkg::line_u  fill_line_i,

  output rdcache_pkg::tag_t   hit_tag_o,
  output logic                hit_valid_o,
  output rdcache_pkg::line_u  hit_line_o
);

  localparam int LINES = 1 << `RC_INDEX_W;

  rdcache_pkg::tag_t  tag_mem  [LINES];
  rdcache_pkg::line_u data_mem [LINES];
  logic [LINES-1:0]   valid_q;
  logic               fill_fwd;

  // Fill to the index being looked up.
  assign fill_fwd = fill_en_i && (fill_index_i == lookup_index_i);

  // ========================================
  // Fill write
  // ========================================
  always_ff @(posedge clk) begin
    if (fill_en_i) begin
      tag_mem[fill_index_i]  <= fill_tag_i;
      data_mem[fill_index_i] <= fill_line_i;
    end
  end

  always_ff @(posedge clk) begin
    if (len_reset) begin
      valid_q <= '0;
    end else if (fill_en_i) begin
      valid_q[fill_index_i] <= 1'b1;
    end
  end

  // ========================================
  // Registered lookup
  // ========================================
  always_ff @(posedge clk) begin
    if (len_reset) begin
      hit_valid_o <= 1'b0;
    end else if (lookup_en_i) begin
      hit_valid_o <= fill_fwd | valid_q[lookup_index_i];
    end
  end

  always_ff @(posedge clk) begin
    if (lookup_en_i) begin
      if (fill_fwd) begin
        hit_tag_o  <= fill_tag_i;          // Fill wins.
        hit_line_o <= fill_line_i;
      end else begin
        hit_tag_o  <= tag_mem[lookup_index_i];
        hit_line_o <= data_mem[lookup_index_i];
      end
    end
  end

endmodule

/* rd_axi.sv */
`timescale 1ns/10ps
`include "rdcache_consts.svh"

module rd_axi (
  input  logic                      clk,
  input  logic                      len_reset,

  input  logic                      rd_addr_valid_i,
  input  logic [`RC_AXI_ADDR_W-1:0] rd_addr_i,
  output logic                      rd_data_valid_o,
  output rdcache_pkg::line_u        rd_data_o,
  output logic                      rd_err_o,

  input  logic                      axi_ar_ready_i,
  output logic                      axi_ar_valid_o,
  output logic [`RC_AXI_ADDR_W-1:0] axi_ar_addr_o,
  output logic [2:0]                axi_ar_prot_o,
  output logic [`RC_AXI_ID_W-1:0]   axi_ar_id_o,
  output logic [7:0]                axi_ar_len_o,
  output logic [2:0]                axi_ar_size_o,
  output logic [1:0]                axi_ar_burst_o,
  output logic                      axi_ar_lock_o,
  output logic [3:0]                axi_ar_cache_o,
  output logic [3:0]                axi_ar_qos_o,

  output logic                      axi_r_ready_o,
  input  logic                      axi_r_valid_i,
  input  logic [1:0]                axi_r_resp_i,
  input  logic [`RC_AXI_DATA_W-1:0] axi_r_data_i,
  input  logic                      axi_r_last_i
);

  localparam logic [1:0] ST_IDLE = 2'd0;
  localparam logic [1:0] ST_ADDR = 2'd1;
  localparam logic [1:0] ST_READ = 2'd2;
  localparam logic [1:0] ST_DONE = 2'd3;

  localparam int BEAT_IDX_W = $clog2(`RC_BEATS);

  logic [1:0]                state_q;
  logic [`RC_AXI_ADDR_W-1:0] addr_q;
  logic [BEAT_IDX_W-1:0]     beat_cnt_q;
  logic                      ar_hs;
  logic                      r_hs;

  assign ar_hs = axi_ar_valid_o && axi_ar_ready_i;
  assign r_hs  = axi_r_ready_o && axi_r_valid_i;

  // ========================================
  // Burst state machine
  // ========================================
  always_ff @(posedge clk) begin
    if (len_reset) begin
      state_q <= ST_IDLE;
    end else begin
      case (state_q)
        ST_IDLE: if (rd_addr_valid_i) state_q <= ST_ADDR;
        ST_ADDR: if (ar_hs) state_q <= ST_READ;
        ST_READ: if (r_hs && axi_r_last_i) state_q <= ST_DONE;
        default: state_q <= ST_IDLE;       // Done lasts one cycle.
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state_q == ST_IDLE && rd_addr_valid_i) begin
      addr_q <= rd_addr_i;
    end
  end

  // ========================================
  // Beat counter and line assembly
  // ========================================
  always_ff @(posedge clk) begin
    if (len_reset || state_q == ST_IDLE) begin
      beat_cnt_q <= '0;
    end else if (r_hs) begin
      beat_cnt_q <= beat_cnt_q + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (r_hs) begin
      rd_data_o.beat[beat_cnt_q] <= axi_r_data_i;
    end
  end

  // Sticky over the whole burst.
  always_ff @(posedge clk) begin
    if (len_reset || state_q == ST_IDLE) begin
      rd_err_o <= 1'b0;
    end else if (r_hs && axi_r_resp_i != `RC_RESP_OKAY) begin
      rd_err_o <= 1'b1;
    end
  end

  assign rd_data_valid_o = (state_q == ST_DONE);

  // ========================================
  // AR channel
  // ========================================
  assign axi_ar_valid_o = (state_q == ST_ADDR);
  assign axi_ar_addr_o  = {addr_q[`RC_AXI_ADDR_W-1:`RC_OFFSET_W], {`RC_OFFSET_W{1'b0}}};
  assign axi_ar_prot_o  = `RC_PROT_DATA;
  assign axi_ar_id_o    = '0;
  assign axi_ar_len_o   = `RC_AXI_LEN;
  assign axi_ar_size_o  = `RC_AXI_SIZE;
  assign axi_ar_burst_o = `RC_BURST_INCR;
  assign axi_ar_lock_o  = 1'b0;
  assign axi_ar_cache_o = `RC_CACHE_NORMAL;
  assign axi_ar_qos_o   = 4'h0;
  assign axi_r_ready_o  = (state_q == ST_READ);

endmodule

/* rdcache_checker.sv */
`timescale 1ns/10ps
`include "rdcache_consts.svh"

module rdcache_checker (
  input logic                      clk,
  input logic                      len_reset,
  input logic                      axi_ar_valid_o,
  input logic                      axi_ar_ready_i,
  input logic [`RC_AXI_ADDR_W-1:0] axi_ar_addr_o,
  input logic [7:0]                axi_ar_len_o,
  input logic                      axi_r_ready_o,
  input logic                      axi_r_valid_i,
  input logic                      axi_r_last_i,
  input logic                      rd_data_valid_o
);

  int   fail_count = 0;
  logic in_burst_q;

  // From AR handshake to the last R beat.
  always_ff @(posedge clk) begin
    if (len_reset) begin
      in_burst_q <= 1'b0;
    end else if (axi_ar_valid_o && axi_ar_ready_i) begin
      in_burst_q <= 1'b1;
    end else if (axi_r_ready_o && axi_r_valid_i && axi_r_last_i) begin
      in_burst_q <= 1'b0;
    end
  end

  // ========================================
  // AXI read channel rules
  // ========================================
  ar_hold: assert property (@(posedge clk) disable iff (len_reset)
    axi_ar_valid_o && !axi_ar_ready_i |=> axi_ar_valid_o && $stable(axi_ar_addr_o))
    else begin
      fail_count++;
      $error("arvalid dropped or araddr changed before arready");
    end

  ar_len: assert property (@(posedge clk) disable iff (len_reset)
    axi_ar_valid_o |-> axi_ar_len_o == `RC_AXI_LEN)
    else begin
      fail_count++;
      $error("arlen differs from the fixed burst length");
    end

  r_ready_in_burst: assert property (@(posedge clk) disable iff (len_reset)
    axi_r_ready_o |-> in_burst_q)
    else begin
      fail_count++;
      $error("rready high outside a burst");
    end

  done_pulse: assert property (@(posedge clk) disable iff (len_reset)
    rd_data_valid_o |=> !rd_data_valid_o)
    else begin
      fail_count++;
      $error("rd_data_valid_o longer than one cycle");
    end

endmodule

bind rd_axi rdcache_checker i_checker (.*);

/* rdcache_consts.svh */
`ifndef RDCACHE_CONSTS_SVH
`define RDCACHE_CONSTS_SVH

// ========================================
// Bus widths
// ========================================
`define RC_AXI_DATA_W   64
`define RC_AXI_ADDR_W   32
`define RC_AXI_ID_W     4
`define RC_WB_DATA_W    32

// ========================================
// Cache geometry
// ========================================
`define RC_LINE_W       128
`define RC_BEATS        2
`define RC_OFFSET_W     4                   // Byte offset within a line.
`define RC_INDEX_W      4                   // 16 lines.
`define RC_TAG_W        (`RC_AXI_ADDR_W - `RC_INDEX_W - `RC_OFFSET_W)

// ========================================
// Fixed AR field codes
// ========================================
`define RC_AXI_LEN      8'd1                // Beats minus one.
`define RC_AXI_SIZE     3'b011              // Eight bytes per beat.
`define RC_BURST_INCR   2'b01
`define RC_PROT_DATA    3'b000              // Unprivileged, secure, data.
`define RC_CACHE_NORMAL 4'b0010             // Normal, non-cacheable, non-bufferable.
`define RC_RESP_OKAY    2'b00

`endif

/* rdcache_pkg.sv */
`include "rdcache_consts.svh"

package rdcache_pkg;

  // Address fields.
  typedef logic [`RC_TAG_W-1:0]   tag_t;
  typedef logic [`RC_INDEX_W-1:0] index_t;

  // One cache line.
  // Filled from the AXI side a beat at a time and read
  // by the Wishbone side a word at a time.
  typedef union packed {
    logic [`RC_BEATS-1:0][`RC_AXI_DATA_W-1:0]                      beat;
    logic [`RC_LINE_W/`RC_WB_DATA_W-1:0][`RC_WB_DATA_W-1:0]        word;
  } line_u;

endpackage

/* rdcache_top.sv */
`timescale 1ns/10ps
`include "rdcache_consts.svh"

module rdcache_top (
  input  logic                      clk,
  input  logic                      len_reset,

  input  logic                      wb_cyc_i,
  input  logic                      wb_stb_i,
  input  logic                      wb_we_i,
  input  logic [`RC_AXI_ADDR_W-1:0] wb_adr_i,
  input  logic [3:0]                wb_sel_i,
  output logic [`RC_WB_DATA_W-1:0]  wb_dat_o,
  output logic                      wb_ack_o,
  output logic                      wb_err_o,

  input  logic                      axi_ar_ready_i,
  output logic                      axi_ar_valid_o,
  output logic [`RC_AXI_ADDR_W-1:0] axi_ar_addr_o,
  output logic [2:0]                axi_ar_prot_o,
  output logic [`RC_AXI_ID_W-1:0]   axi_ar_id_o,
  output logic [7:0]                axi_ar_len_o,
  output logic [2:0]                axi_ar_size_o,
  output logic [1:0]                axi_ar_burst_o,
  output logic                      axi_ar_lock_o,
  output logic [3:0]                axi_ar_cache_o,
  output logic [3:0]                axi_ar_qos_o,

  output logic                      axi_r_ready_o,
  input  logic                      axi_r_valid_i,
  input  logic [1:0]                axi_r_resp_i,
  input  logic [`RC_AXI_DATA_W-1:0] axi_r_data_i,
  input  logic                      axi_r_last_i
);

  // Control to store.
  logic                      lookup_en;
  rdcache_pkg::index_t       lookup_index;
  rdcache_pkg::tag_t         hit_tag;
  logic                      hit_valid;
  rdcache_pkg::line_u        hit_line;
  logic                      fill_en;
  rdcache_pkg::index_t       fill_index;
  rdcache_pkg::tag_t         fill_tag;
  rdcache_pkg::line_u        fill_line;

  // Control to AXI engine.
  logic                      rd_addr_valid;
  logic [`RC_AXI_ADDR_W-1:0] rd_addr;
  logic                      rd_data_valid;
  rdcache_pkg::line_u        rd_data;
  logic                      rd_err;

  wb_read_cache i_ctrl (
    .clk             (clk),
    .len_reset       (len_reset),
    .wb_cyc_i        (wb_cyc_i),
    .wb_stb_i        (wb_stb_i),
    .wb_we_i         (wb_we_i),
    .wb_adr_i        (wb_adr_i),
    .wb_sel_i        (wb_sel_i),
    .wb_dat_o        (wb_dat_o),
    .wb_ack_o        (wb_ack_o),
    .wb_err_o        (wb_err_o),
    .lookup_en_o     (lookup_en),
    .lookup_index_o  (lookup_index),
    .hit_tag_i       (hit_tag),
    .hit_valid_i     (hit_valid),
    .hit_line_i      (hit_line),
    .fill_en_o       (fill_en),
    .fill_index_o    (fill_index),
    .fill_tag_o      (fill_tag),
    .fill_line_o     (fill_line),
    .rd_addr_valid_o (rd_addr_valid),
    .rd_addr_o       (rd_addr),
    .rd_data_valid_i (rd_data_valid),
    .rd_data_i       (rd_data),
    .rd_err_i        (rd_err)
  );

  line_store i_store (
    .clk            (clk),
    .len_reset      (len_reset),
    .lookup_en_i    (lookup_en),
    .lookup_index_i (lookup_index),
    .fill_en_i      (fill_en),
    .fill_index_i   (fill_index),
    .fill_tag_i     (fill_tag),
    .fill_line_i    (fill_line),
    .hit_tag_o      (hit_tag),
    .hit_valid_o    (hit_valid),
    .hit_line_o     (hit_line)
  );

  rd_axi i_axi (
    .clk             (clk),
    .len_reset       (len_reset),
    .rd_addr_valid_i (rd_addr_valid),
    .rd_addr_i       (rd_addr),
    .rd_data_valid_o (rd_data_valid),
    .rd_data_o       (rd_data),
    .rd_err_o        (rd_err),
    .axi_ar_ready_i  (axi_ar_ready_i),
    .axi_ar_valid_o  (axi_ar_valid_o),
    .axi_ar_addr_o   (axi_ar_addr_o),
    .axi_ar_prot_o   (axi_ar_prot_o),
    .axi_ar_id_o     (axi_ar_id_o),
    .axi_ar_len_o    (axi_ar_len_o),
    .axi_ar_size_o   (axi_ar_size_o),
    .axi_ar_burst_o  (axi_ar_burst_o),
    .axi_ar_lock_o   (axi_ar_lock_o),
    .axi_ar_cache_o  (axi_ar_cache_o),
    .axi_ar_qos_o    (axi_ar_qos_o),
    .axi_r_ready_o   (axi_r_ready_o),
    .axi_r_valid_i   (axi_r_valid_i),
    .axi_r_resp_i    (axi_r_resp_i),
    .axi_r_data_i    (axi_r_data_i),
    .axi_r_last_i    (axi_r_last_i)
  );

endmodule

/* run.sh */
#!/usr/bin/env bash
# Build and run the read cache testbench with Verilator.
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f sources.f --top-module tb_rdcache -o sim_rdcache \
  && ./obj_dir/sim_rdcache +verilator+error+limit+100 > sim.log 2>&1 \
  || echo "Build or simulation did not complete"
cat sim.log 2>/dev/null
grep -q "^RESULT: PASS$" sim.log && echo "Simulation passed" || { echo "Simulation failed"; exit 1; }

/* sources.f */
+incdir+.
rdcache_pkg.sv
rd_axi.sv
line_store.sv
wb_read_cache.sv
rdcache_top.sv
rdcache_checker.sv
tb_rdcache.sv

/* tb_rdcache.sv */
`timescale 1ns/10ps
`include "rdcache_consts.svh"

module tb_rdcache;

  localparam int TIMEOUT = 100;

  logic                      clk = 1'b0;
  logic                      len_reset;
  logic                      wb_cyc_i;
  logic                      wb_stb_i;
  logic                      wb_we_i;
  logic [`RC_AXI_ADDR_W-1:0] wb_adr_i;
  logic [3:0]                wb_sel_i;
  logic [`RC_WB_DATA_W-1:0]  wb_dat_o;
  logic                      wb_ack_o;
  logic                      wb_err_o;
  logic                      axi_ar_ready_i;
  logic                      axi_ar_valid_o;
  logic [`RC_AXI_ADDR_W-1:0] axi_ar_addr_o;
  logic [2:0]                axi_ar_prot_o;
  logic [`RC_AXI_ID_W-1:0]   axi_ar_id_o;
  logic [7:0]                axi_ar_len_o;
  logic [2:0]                axi_ar_size_o;
  logic [1:0]                axi_ar_burst_o;
  logic                      axi_ar_lock_o;
  logic [3:0]                axi_ar_cache_o;
  logic [3:0]                axi_ar_qos_o;
  logic                      axi_r_ready_o;
  logic                      axi_r_valid_i;
  logic [1:0]                axi_r_resp_i;
  logic [`RC_AXI_DATA_W-1:0] axi_r_data_i;
  logic                      axi_r_last_i;

  logic [31:0]               stim_lfsr = 32'hdb30_2f11;
  logic [31:0]               mem_lfsr  = 32'hdb30_2f11;
  rdcache_pkg::tag_t         ref_tag [16];          // Reference tag table.
  logic [15:0]               ref_valid;
  logic [`RC_AXI_ADDR_W-1:0] exp_ar_addr;
  int                        ar_count;
  int                        lines_seen;
  rdcache_pkg::line_u        line_seen;

  rdcache_top i_dut (.*);

  always #5 clk = ~clk;

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [31:0] stim_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      stim_lfsr = lfsr_next(stim_lfsr);
      r = {r[30:0], stim_lfsr[0]};
    end
    return r;
  endfunction

  function automatic logic mem_bit();
    mem_lfsr = lfsr_next(mem_lfsr);
    return mem_lfsr[0];
  endfunction

  // Memory word at a byte address.
  function automatic logic [31:0] word_at(input logic [31:0] a);
    return (a * 32'h9e37_79b9) ^ 32'h3c96_a55a;
  endfunction

  // ========================================
  // Compare tasks
  // ========================================
  task automatic stop_with_failure(input string why);
    $display("%s", why);
    $display("RESULT: FAIL");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_word(input string name, input logic [`RC_WB_DATA_W-1:0] got,
                            input logic [`RC_WB_DATA_W-1:0] exp);
    if (got !== exp) begin
      stop_with_failure($sformatf("FAILED at %0t: %s got %h expected %h", $time, name, got, exp));
    end
  endtask

  task automatic check_resp(input string name, input logic [1:0] got, input logic [1:0] exp);
    if (got !== exp) begin
      stop_with_failure($sformatf("FAILED at %0t: %s got %b expected %b", $time, name, got, exp));
    end
  endtask

  task automatic check_line(input string name, input rdcache_pkg::line_u got,
                            input rdcache_pkg::line_u exp);
    if (got !== exp) begin
      stop_with_failure($sformatf("FAILED at %0t: %s got %h expected %h", $time, name, got, exp));
    end
  endtask

  task automatic check_count(input string name, input int got, input int exp);
    if (got != exp) begin
      stop_with_failure($sformatf("FAILED at %0t: %s got %0d expected %0d", $time, name, got, exp));
    end
  endtask

  // ========================================
  // Wishbone master and reference model
  // ========================================
  task automatic wb_access(input logic we, input logic [31:0] adr);
    rdcache_pkg::index_t idx;
    rdcache_pkg::tag_t   tag;
    rdcache_pkg::line_u  exp_line;
    logic                hit;
    int                  ar_before;
    int                  lines_before;
    int                  cycles;
    idx = adr[`RC_OFFSET_W +: `RC_INDEX_W];
    tag = adr[`RC_AXI_ADDR_W-1 -: `RC_TAG_W];
    hit = ref_valid[idx] && (ref_tag[idx] == tag);
    for (int i = 0; i < 4; i++) begin
      exp_line.word[i] = word_at({adr[31:4], 4'h0} + 32'(4 * i));
    end
    exp_ar_addr  = {adr[31:4], 4'h0};
    ar_before    = ar_count;
    lines_before = lines_seen;
    wb_cyc_i = 1'b1;
    wb_stb_i = 1'b1;
    wb_we_i  = we;
    wb_adr_i = adr;
    wb_sel_i = 4'hf;
    cycles   = 0;
    do begin
      @(posedge clk);
      #1;
      cycles++;
      if (cycles > TIMEOUT) begin
        stop_with_failure("no ack or err came back from the cache in time");
      end
    end while (!wb_ack_o && !wb_err_o);
    if (we) begin
      check_resp("write ack/err", {wb_ack_o, wb_err_o}, 2'b01);
      check_count("write latency", cycles, 1);
      check_count("write ar transfers", ar_count - ar_before, 0);
    end else if (hit) begin
      check_resp("hit ack/err", {wb_ack_o, wb_err_o}, 2'b10);
      check_count("hit latency", cycles, 2);              // Ack two edges after stb.
      check_count("hit ar transfers", ar_count - ar_before, 0);
      check_word("hit wb_dat_o", wb_dat_o, exp_line.word[adr[3:2]]);
    end else begin
      check_count("miss ar transfers", ar_count - ar_before, 1);
      if (adr[31:28] == 4'he) begin
        check_resp("error read ack/err", {wb_ack_o, wb_err_o}, 2'b01);
      end else begin
        check_resp("miss ack/err", {wb_ack_o, wb_err_o}, 2'b10);
        check_word("miss wb_dat_o", wb_dat_o, exp_line.word[adr[3:2]]);
        check_count("refill lines", lines_seen - lines_before, 1);
        check_line("refill line", line_seen, exp_line);
        ref_valid[idx] = 1'b1;
        ref_tag[idx]   = tag;
      end
    end
    @(posedge clk);
    #1;
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    wb_we_i  = 1'b0;
  endtask

  // ========================================
  // AXI memory model
  // ========================================
  initial begin
    logic                      ar_fire;
    logic                      r_fire;
    logic                      burst_on;
    logic                      beat_sel;
    logic [`RC_AXI_ADDR_W-1:0] burst_addr;
    axi_ar_ready_i = 1'b0;
    axi_r_valid_i  = 1'b0;
    axi_r_resp_i   = 2'b00;
    axi_r_data_i   = '0;
    axi_r_last_i   = 1'b0;
    ar_count       = 0;
    lines_seen     = 0;
    burst_on       = 1'b0;
    beat_sel       = 1'b0;
    burst_addr     = '0;
    forever begin
      @(negedge clk);
      ar_fire = axi_ar_valid_o && axi_ar_ready_i;
      r_fire  = axi_r_valid_i && axi_r_ready_o;
      if (ar_fire) begin
        check_word("axi_ar_addr_o", axi_ar_addr_o, exp_ar_addr);
        check_word("axi_ar_len_o", 32'(axi_ar_len_o), 32'd1);         // Two beats.
        check_word("axi_ar_size_o", 32'(axi_ar_size_o), 32'(3'b011)); // Eight bytes.
        check_word("axi_ar_burst_o", 32'(axi_ar_burst_o), 32'(2'b01));  // INCR.
        check_word("axi_ar_id_o", 32'(axi_ar_id_o), 32'd0);
        check_word("axi_ar_lock_o", 32'(axi_ar_lock_o), 32'd0);
        check_word("axi_ar_prot_o", 32'(axi_ar_prot_o), 32'(3'b000));
        check_word("axi_ar_cache_o", 32'(axi_ar_cache_o), 32'(4'b0010));
        check_word("axi_ar_qos_o", 32'(axi_ar_qos_o), 32'd0);
        burst_addr = axi_ar_addr_o;
      end
      if (i_dut.rd_data_valid) begin
        line_seen = i_dut.rd_data;
        lines_seen++;
      end
      if (i_dut.i_axi.i_checker.fail_count != 0) begin
        stop_with_failure("an AXI read channel assertion failed");
      end
      @(posedge clk);
      #1;
      if (ar_fire) begin
        ar_count++;
        burst_on = 1'b1;
        beat_sel = 1'b0;
      end
      if (r_fire) begin
        burst_on = burst_on && !beat_sel;                // Second beat ends the burst.
        beat_sel = !beat_sel;
      end
      axi_ar_ready_i = mem_bit();
      if (!burst_on) begin
        axi_r_valid_i = 1'b0;
      end else if (!axi_r_valid_i || r_fire) begin
        axi_r_valid_i = mem_bit() | mem_bit();
      end
      axi_r_data_i = {word_at({burst_addr[31:4], beat_sel, 3'b100}),
                      word_at({burst_addr[31:4], beat_sel, 3'b000})};
      axi_r_last_i = beat_sel;
      axi_r_resp_i = (burst_addr[31:28] == 4'he && !beat_sel) ? 2'b10 : 2'b00;  // SLVERR.
    end
  end

  // ========================================
  // Test sequence
  // ========================================
  initial begin
    logic [31:0] kind;
    logic [31:0] pick;
    len_reset   = 1'b1;
    wb_cyc_i    = 1'b0;
    wb_stb_i    = 1'b0;
    wb_we_i     = 1'b0;
    wb_adr_i    = '0;
    wb_sel_i    = 4'h0;
    ref_valid   = '0;
    exp_ar_addr = '0;
    repeat (10) @(posedge clk);
    #1;
    len_reset = 1'b0;
    check_resp("ack/err after reset", {wb_ack_o, wb_err_o}, 2'b00);
    check_resp("arvalid/rready after reset", {axi_ar_valid_o, axi_r_ready_o}, 2'b00);
    wb_access(1'b0, 32'h0000_1234);
    wb_access(1'b0, 32'h0000_1234);
    wb_access(1'b0, 32'h0000_1238);
    wb_access(1'b0, 32'h0001_1230);                      // Same index, other tag.
    wb_access(1'b0, 32'h0000_123c);
    wb_access(1'b1, 32'h0000_1234);
    wb_access(1'b0, 32'he000_0040);
    wb_access(1'b0, 32'he000_0044);
    for (int n = 0; n < 300; n++) begin
      kind = stim_bits(4);
      pick = stim_bits(8);
      wb_access(kind == 32'd1, {(kind == 32'd0) ? 4'he : 4'h1, 18'd0, pick[7:0], 2'b00});
    end
    if (i_dut.i_axi.i_checker.fail_count == 0) begin
      $display("RESULT: PASS");
      $finish;
    end else begin
      stop_with_failure("an AXI read channel assertion failed");
    end
  end

endmodule

/* wb_read_cache.sv */
`timescale 1ns/10ps
`include "rdcache_consts.svh"

module wb_read_cache (
  input  logic                      clk,
  input  logic                      len_reset,

  input  logic                      wb_cyc_i,
  input  logic                      wb_stb_i,
  input  logic                      wb_we_i,
  input  logic [`RC_AXI_ADDR_W-1:0] wb_adr_i,
  input  logic [3:0]                wb_sel_i,
  output logic [`RC_WB_DATA_W-1:0]  wb_dat_o,
  output logic                      wb_ack_o,
  output logic                      wb_err_o,

  output logic                      lookup_en_o,
  output rdcache_pkg::index_t       lookup_index_o,
  input  rdcache_pkg::tag_t         hit_tag_i,
  input  logic                      hit_valid_i,
  input  rdcache_pkg::line_u        hit_line_i,

  output logic                      fill_en_o,
  output rdcache_pkg::index_t       fill_index_o,
  output rdcache_pkg::tag_t         fill_tag_o,
  output rdcache_pkg::line_u        fill_line_o,

  output logic                      rd_addr_valid_o,
  output logic [`RC_AXI_ADDR_W-1:0] rd_addr_o,
  input  logic                      rd_data_valid_i,
  input  rdcache_pkg::line_u        rd_data_i,
  input  logic                      rd_err_i
);

  localparam logic [2:0] ST_IDLE    = 3'd0;
  localparam logic [2:0] ST_LOOKUP  = 3'd1;
  localparam logic [2:0] ST_COMPARE = 3'd2;
  localparam logic [2:0] ST_REFILL  = 3'd3;
  localparam logic [2:0] ST_RESPOND = 3'd4;

  localparam int WORD_W = $clog2(`RC_LINE_W / `RC_WB_DATA_W);
  localparam int BYTE_W = $clog2(`RC_WB_DATA_W / 8);

  logic [2:0]          state_q;
  logic                err_q;
  rdcache_pkg::tag_t   tag_q;
  rdcache_pkg::index_t index_q;
  logic [WORD_W-1:0]   word_q;
  rdcache_pkg::line_u  line_q;
  logic                hit;

  assign hit = hit_valid_i && (hit_tag_i == tag_q);

  // ========================================
  // Control FSM
  // ========================================
  always_ff @(posedge clk) begin
    if (len_reset) begin
      state_q <= ST_IDLE;
      err_q   <= 1'b0;
    end else begin
      case (state_q)
        ST_IDLE: begin
          if (wb_cyc_i && wb_stb_i) begin
            state_q <= wb_we_i ? ST_RESPOND : ST_LOOKUP;
            err_q   <= wb_we_i;            // Writes are not supported.
          end
        end
        ST_LOOKUP:  state_q <= ST_COMPARE;
        ST_COMPARE: state_q <= hit ? ST_IDLE : ST_REFILL;
        ST_REFILL: begin
          if (rd_data_valid_i) begin
            state_q <= ST_RESPOND;
            err_q   <= rd_err_i;
          end
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  // Address split, taken once per cycle.
  always_ff @(posedge clk) begin
    if (state_q == ST_IDLE && wb_cyc_i && wb_stb_i) begin
      tag_q   <= wb_adr_i[`RC_AXI_ADDR_W-1 -: `RC_TAG_W];
      index_q <= wb_adr_i[`RC_OFFSET_W +: `RC_INDEX_W];
      word_q  <= wb_adr_i[BYTE_W +: WORD_W];
    end
  end

  always_ff @(posedge clk) begin
    if (state_q == ST_REFILL && rd_data_valid_i) begin
      line_q <= rd_data_i;
    end
  end

  // ========================================
  // Store and engine requests
  // ========================================
  assign lookup_en_o     = (state_q == ST_LOOKUP);
  assign lookup_index_o  = index_q;
  assign fill_en_o       = (state_q == ST_REFILL) && rd_data_valid_i && !rd_err_i;
  assign fill_index_o    = index_q;
  assign fill_tag_o      = tag_q;
  assign fill_line_o     = rd_data_i;
  assign rd_addr_valid_o = (state_q == ST_COMPARE) && !hit;   // One-cycle pulse.
  assign rd_addr_o       = {tag_q, index_q, {`RC_OFFSET_W{1'b0}}};

  // ========================================
  // Wishbone response
  // ========================================
  assign wb_ack_o = ((state_q == ST_COMPARE) && hit) || ((state_q == ST_RESPOND) && !err_q);
  assign wb_err_o = (state_q == ST_RESPOND) && err_q;
  assign wb_dat_o = (state_q == ST_COMPARE) ? hit_line_i.word[word_q] : line_q.word[word_q];

endmodule
